// File: verilog/map_pkg.sv
`default_nettype none

package map_pkg;

  ////////////////////////////////////////////////////////////
  // mapper codes
  ////////////////////////////////////////////////////////////

  // mapper code as detected by the MCU
  // codes 3..6 decode as unmapped
  typedef enum logic [2:0] {
    MAP_HIROM   = 3'd0,
    MAP_LOROM   = 3'd1,
    MAP_EXHIROM = 3'd2,
    MAP_MENU    = 3'd7
  } mapper_e;

  // bit positions inside featurebits
  // bit 1 is the ST0010 bit, not supported here
  typedef enum logic [2:0] {
    FEAT_DSPX = 3'd0,
    FEAT_SRTC = 3'd2,
    FEAT_MSU1 = 3'd3,
    FEAT_213F = 3'd4
  } feat_e;

  ////////////////////////////////////////////////////////////
  // physical memory layout
  ////////////////////////////////////////////////////////////

  // save RAM lives at the top of SRAM
  localparam logic [23:0] SAVERAM_BASE   = 24'hE00000;
  // menu keeps its own save area and ROM image
  localparam logic [23:0] MENU_SRAM_BASE = 24'hFF0000;
  localparam logic [23:0] MENU_ROM_BASE  = 24'hC00000;

  // feature windows, SNES side
  localparam logic [15:0] MSU_WIN  = 16'h2000;
  localparam logic [15:0] SRTC_WIN = 16'h2800;
  localparam logic [23:0] CMD_WIN  = 24'hCCCCC0;
  // peripheral address of the 213F latch
  localparam logic [7:0]  PA_213F  = 8'h3F;

endpackage

`default_nettype wire

// File: verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

  ////////////////////////////////////////////////////////////
  // register ports
  ////////////////////////////////////////////////////////////

  // one port per decoded window
  localparam int NUM_PORTS = 3;

  // index into port_sel and port_rdata
  localparam int PORT_MSU  = 0;
  localparam int PORT_SRTC = 1;
  localparam int PORT_CMD  = 2;

  ////////////////////////////////////////////////////////////
  // sampler state
  ////////////////////////////////////////////////////////////

  // bus cycle in progress, as seen after the synchronizer
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } cycle_e;

endpackage

`default_nettype wire

// File: verilog/snes_bus_sampler.sv
`default_nettype none

module snes_bus_sampler import bus_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic        CLK,
  input  logic        rst,
  input  logic [23:0] snes_addr,
  input  logic [7:0]  snes_pa,
  input  logic        snes_rd_n,
  input  logic        snes_wr_n,
  input  logic [7:0]  snes_data_in,
  output logic [23:0] ev_addr,
  output logic [7:0]  ev_pa,
  output logic [7:0]  ev_data,
  output logic        rd_ev,
  output logic        wr_ev
);

  ////////////////////////////////////////////////////////////
  // strobe synchronizers
  ////////////////////////////////////////////////////////////

  // bit 0 takes the pin, top bit feeds the FSM
  logic [SYNC_STAGES-1:0] rd_sync;
  logic [SYNC_STAGES-1:0] wr_sync;
  logic                   rd_s;
  logic                   wr_s;

  // strobes idle high, so reset fills with ones
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_sync <= '1;
      wr_sync <= '1;
    end else begin
      rd_sync <= {rd_sync[SYNC_STAGES-2:0], snes_rd_n};
      wr_sync <= {wr_sync[SYNC_STAGES-2:0], snes_wr_n};
    end
  end

  assign rd_s = rd_sync[SYNC_STAGES-1];
  assign wr_s = wr_sync[SYNC_STAGES-1];

  ////////////////////////////////////////////////////////////
  // cycle FSM
  ////////////////////////////////////////////////////////////

  cycle_e state;
  cycle_e state_nxt;
  logic   rd_fire;
  logic   wr_fire;

  // the FSM doubles as falling edge detect
  // a strobe held low stays in READ/WRITE, no second event
  always_comb begin
    state_nxt = state;
    rd_fire   = 1'b0;
    wr_fire   = 1'b0;
    case (state)
      IDLE: begin
        // read wins if both fall together
        if (!rd_s) begin
          rd_fire   = 1'b1;
          state_nxt = READ;
        end else if (!wr_s) begin
          wr_fire   = 1'b1;
          state_nxt = WRITE;
        end
      end
      READ:    if (rd_s) state_nxt = IDLE;
      WRITE:   if (wr_s) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= IDLE;
      rd_ev <= 1'b0;
      wr_ev <= 1'b0;
    end else begin
      state <= state_nxt;
      rd_ev <= rd_fire;
      wr_ev <= wr_fire;
    end
  end

  // bus is stable for the whole strobe, capture with the event
  always_ff @(posedge CLK) begin
    if (rd_fire || wr_fire) begin
      ev_addr <= snes_addr;
      ev_pa   <= snes_pa;
      ev_data <= snes_data_in;
    end
  end

endmodule

`default_nettype wire

// File: verilog/address.sv
`default_nettype none

module address import map_pkg::*, bus_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic [2:0]           mapper,
  input  logic [7:0]           featurebits,
  input  logic [23:0]          saveram_mask,
  input  logic [23:0]          rom_mask,
  input  logic [23:0]          ev_addr,
  input  logic [7:0]           ev_pa,
  input  logic                 rd_ev,
  input  logic                 wr_ev,
  output logic [23:0]          rom_addr,
  output logic                 is_rom,
  output logic                 is_saveram,
  output logic                 is_writable,
  output logic [NUM_PORTS-1:0] port_sel,
  output logic                 dspx_enable,
  output logic                 dspx_a0,
  output logic                 rd_hit,
  output logic                 wr_hit
);

  logic                 is_hirom;
  logic                 is_lorom;
  logic                 is_menu;
  logic                 mapped;
  logic                 sram_win;
  logic                 sram_w;
  logic                 rom_w;
  logic [14:0]          menu_off;
  logic [23:0]          sram_off;
  logic [23:0]          rom_off;
  logic [23:0]          addr_w;
  logic                 msu_w;
  logic                 srtc_w;
  logic                 cmd_w;
  logic                 r213f_w;
  logic                 dspx_w;
  logic                 a0_w;
  logic [NUM_PORTS-1:0] sel_w;

  ////////////////////////////////////////////////////////////
  // mapper translation
  ////////////////////////////////////////////////////////////

  // menu save area is addressed from 6000
  assign menu_off = ev_addr[14:0] - 15'h6000;

  always_comb begin
    mapped   = 1'b1;
    sram_win = 1'b0;
    sram_off = '0;
    rom_off  = '0;
    case (mapper)
      MAP_HIROM: begin
        // 20-3f/a0-bf:6000-7fff
        sram_win = ~ev_addr[22] & ev_addr[21] & &ev_addr[14:13] & ~ev_addr[15];
        sram_off = {6'd0, ev_addr[20:16], ev_addr[12:0]};
        rom_off  = {1'b0, ev_addr[22:0]};
      end
      MAP_LOROM: begin
        // 70-7d/f0-fd:0000-7fff
        sram_win = &ev_addr[22:20] & (ev_addr[19:16] < 4'hE) & ~ev_addr[15];
        sram_off = {4'd0, ev_addr[20:16], ev_addr[14:0]};
        // drop A15, 32k banks folded together
        rom_off  = {2'b00, ev_addr[22:16], ev_addr[14:0]};
      end
      MAP_EXHIROM: begin
        sram_win = ~ev_addr[22] & ev_addr[21] & &ev_addr[14:13] & ~ev_addr[15];
        sram_off = {6'd0, ev_addr[20:16], ev_addr[12:0]};
        // c0-ff first, then 40-7f
        rom_off  = {1'b0, ~ev_addr[23], ev_addr[21:0]};
      end
      MAP_MENU: begin
        sram_win = ~ev_addr[22] & ev_addr[21] & &ev_addr[14:13] & ~ev_addr[15];
        sram_off = {9'd0, menu_off};
        rom_off  = {1'b0, ev_addr[22:0]};
      end
      default: mapped = 1'b0;
    endcase
  end

  assign is_hirom = (mapper == MAP_HIROM);
  assign is_lorom = (mapper == MAP_LOROM);
  assign is_menu  = (mapper == MAP_MENU);

  // mask bit 0 clear means no save RAM at all
  assign sram_w = saveram_mask[0] & sram_win;
  assign rom_w  = mapped & (ev_addr[22] | ev_addr[15]);

  always_comb begin
    if (!mapped) begin
      addr_w = '0;
    end else if (sram_w) begin
      addr_w = (is_menu ? MENU_SRAM_BASE : SAVERAM_BASE) + (sram_off & saveram_mask);
    end else if (is_menu) begin
      addr_w = (rom_off & rom_mask) + MENU_ROM_BASE;
    end else begin
      addr_w = rom_off & rom_mask;
    end
  end

  ////////////////////////////////////////////////////////////
  // feature windows
  ////////////////////////////////////////////////////////////

  // MSU1 at 2000-2007, SRTC at 2800-2801, system banks only
  assign msu_w  = featurebits[FEAT_MSU1] & ~ev_addr[22]
                & ((ev_addr[15:0] & 16'hFFF8) == MSU_WIN);
  assign srtc_w = featurebits[FEAT_SRTC] & ~ev_addr[22]
                & ((ev_addr[15:0] & 16'hFFFE) == SRTC_WIN);
  // command area cc:ccc0-cccf, always on
  assign cmd_w  = (ev_addr[23:4] == CMD_WIN[23:4]);
  // peripheral bus, independent of the A bus
  assign r213f_w = featurebits[FEAT_213F] & (ev_pa == PA_213F);

  // 213F lands on the MSU port and takes priority
  // so at most one select is ever set
  always_comb begin
    sel_w            = '0;
    sel_w[PORT_MSU]  = msu_w | r213f_w;
    sel_w[PORT_SRTC] = srtc_w & ~r213f_w;
    sel_w[PORT_CMD]  = cmd_w & ~r213f_w;
  end

  // DSP1 LoROM: 30-3f:8000-ffff, or 60-6f:0000-7fff for big ROMs
  // DSP1 HiROM: 00-0f:6000-7fff
  always_comb begin
    dspx_w = 1'b0;
    a0_w   = 1'b1;
    if (featurebits[FEAT_DSPX]) begin
      if (is_lorom) begin
        dspx_w = rom_mask[20]
               ? (ev_addr[22] & ev_addr[21] & ~ev_addr[20] & ~ev_addr[15])
               : (~ev_addr[22] & ev_addr[21] & ev_addr[20] & ev_addr[15]);
        a0_w   = ev_addr[14];
      end else if (is_hirom) begin
        dspx_w = ~ev_addr[22] & ~ev_addr[21] & ~ev_addr[20] & ~ev_addr[15]
               & &ev_addr[14:13];
        a0_w   = ev_addr[12];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  // hits trail the events by one, aligned with the selects
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_hit      <= 1'b0;
      wr_hit      <= 1'b0;
      port_sel    <= '0;
      dspx_enable <= 1'b0;
      is_rom      <= 1'b0;
      is_saveram  <= 1'b0;
      is_writable <= 1'b0;
    end else begin
      rd_hit <= rd_ev;
      wr_hit <= wr_ev;
      if (rd_ev || wr_ev) begin
        port_sel    <= sel_w;
        dspx_enable <= dspx_w;
        is_rom      <= rom_w;
        is_saveram  <= sram_w;
        // only save RAM is writable without BS-X
        is_writable <= sram_w;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_ev || wr_ev) begin
      rom_addr <= addr_w;
      dspx_a0  <= a0_w;
    end
  end

endmodule

`default_nettype wire

// File: verilog/io_port.sv
`default_nettype none

module io_port (
  input  logic       CLK,
  input  logic       rst,
  input  logic       sel,
  input  logic       rd_hit,
  input  logic       wr_hit,
  input  logic [2:0] reg_idx,
  input  logic [7:0] wdata,
  output logic [7:0] rdata
);

  ////////////////////////////////////////////////////////////
  // register window
  ////////////////////////////////////////////////////////////

  // eight bytes, one per low address bit pattern
  logic [7:0] regs [8];
  logic       wr_en;

  // read and write never overlap on the bus
  // if they ever do, the read wins and nothing is written
  assign wr_en = sel & wr_hit & ~rd_hit;

  always_ff @(posedge CLK) begin
    if (rst) begin
      // window reads back zero after reset
      for (int i = 0; i < 8; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (wr_en) begin
      regs[reg_idx] <= wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  // always the addressed byte
  // the mux decides when to take it
  assign rdata = regs[reg_idx];

endmodule

`default_nettype wire

// File: verilog/port_read_mux.sv
`default_nettype none

module port_read_mux import bus_pkg::*; (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic [NUM_PORTS-1:0]      port_sel,
  input  logic                      rd_hit,
  input  logic [NUM_PORTS-1:0][7:0] port_rdata,
  output logic [7:0]                rd_data,
  output logic                      rd_valid
);

  ////////////////////////////////////////////////////////////
  // port select
  ////////////////////////////////////////////////////////////

  logic [7:0] pick;

  // selects are one-hot or zero
  // open bus reads as ff
  always_comb begin
    pick = 8'hFF;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (port_sel[i]) begin
        pick = port_rdata[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read data register
  ////////////////////////////////////////////////////////////

  // one valid pulse per read
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_hit;
    end
  end

  // data holds until the next read
  always_ff @(posedge CLK) begin
    if (rd_hit) begin
      rd_data <= pick;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cart_top.sv
`default_nettype none

module cart_top import map_pkg::*, bus_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic [23:0]          snes_addr,
  input  logic [7:0]           snes_pa,
  input  logic                 snes_rd_n,
  input  logic                 snes_wr_n,
  input  logic [7:0]           snes_data_in,
  input  logic [2:0]           mapper,
  input  logic [7:0]           featurebits,
  input  logic [23:0]          saveram_mask,
  input  logic [23:0]          rom_mask,
  output logic [23:0]          rom_addr,
  output logic                 is_rom,
  output logic                 is_saveram,
  output logic                 is_writable,
  output logic [NUM_PORTS-1:0] port_sel,
  output logic                 dspx_enable,
  output logic                 dspx_a0,
  output logic [7:0]           rd_data,
  output logic                 rd_valid
);

  logic [23:0]                ev_addr;
  logic [7:0]                 ev_pa;
  logic [7:0]                 ev_data;
  logic                       rd_ev;
  logic                       wr_ev;
  logic                       rd_hit;
  logic                       wr_hit;
  logic                       sel_213f;
  logic [NUM_PORTS-1:0][7:0]  port_rdata;

  ////////////////////////////////////////////////////////////
  // bus front end and decoder
  ////////////////////////////////////////////////////////////

  snes_bus_sampler #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_sampler (
    .CLK          (CLK),
    .rst          (rst),
    .snes_addr    (snes_addr),
    .snes_pa      (snes_pa),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_data_in (snes_data_in),
    .ev_addr      (ev_addr),
    .ev_pa        (ev_pa),
    .ev_data      (ev_data),
    .rd_ev        (rd_ev),
    .wr_ev        (wr_ev)
  );

  address u_address (
    .CLK          (CLK),
    .rst          (rst),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .saveram_mask (saveram_mask),
    .rom_mask     (rom_mask),
    .ev_addr      (ev_addr),
    .ev_pa        (ev_pa),
    .rd_ev        (rd_ev),
    .wr_ev        (wr_ev),
    .rom_addr     (rom_addr),
    .is_rom       (is_rom),
    .is_saveram   (is_saveram),
    .is_writable  (is_writable),
    .port_sel     (port_sel),
    .dspx_enable  (dspx_enable),
    .dspx_a0      (dspx_a0),
    .rd_hit       (rd_hit),
    .wr_hit       (wr_hit)
  );

  ////////////////////////////////////////////////////////////
  // register ports
  ////////////////////////////////////////////////////////////

  // same condition the decoder gives priority to
  assign sel_213f = featurebits[FEAT_213F] & (ev_pa == PA_213F);

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    logic [2:0] reg_idx;

    // MSU port also serves 213F, indexed by the PA bus
    if (p == PORT_MSU) begin : g_idx_pa
      assign reg_idx = sel_213f ? ev_pa[2:0] : ev_addr[2:0];
    end else begin : g_idx_addr
      assign reg_idx = ev_addr[2:0];
    end

    io_port u_port (
      .CLK     (CLK),
      .rst     (rst),
      .sel     (port_sel[p]),
      .rd_hit  (rd_hit),
      .wr_hit  (wr_hit),
      .reg_idx (reg_idx),
      .wdata   (ev_data),
      .rdata   (port_rdata[p])
    );
  end

  port_read_mux u_mux (
    .CLK        (CLK),
    .rst        (rst),
    .port_sel   (port_sel),
    .rd_hit     (rd_hit),
    .port_rdata (port_rdata),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid)
  );

endmodule

`default_nettype wire

// File: tb/cart_checker.sv
`default_nettype none

module cart_checker import bus_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input logic                 CLK,
  input logic                 rst,
  input logic                 snes_rd_n,
  input logic                 rd_valid,
  input logic [NUM_PORTS-1:0] port_sel
);

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  // every valid traces back to one falling read strobe
  // so two valids in a row would need two falls in a row
  a_valid_once: assert property (@(posedge CLK) disable iff (rst)
    rd_valid |-> ($past(snes_rd_n, SYNC_STAGES + 4) && !$past(snes_rd_n, SYNC_STAGES + 3)))
    else $error("rd_valid high without a read strobe falling in time before it");

  // sync reset, so check from the second reset cycle on
  a_valid_reset: assert property (@(posedge CLK)
    (rst && $past(rst)) |-> !rd_valid)
    else $error("rd_valid high during reset");

  ////////////////////////////////////////////////////////////
  // decoder selects
  ////////////////////////////////////////////////////////////

  a_sel_onehot: assert property (@(posedge CLK) disable iff (rst)
    $onehot0(port_sel))
    else $error("more than one port selected");

endmodule

bind cart_top cart_checker #(
  .SYNC_STAGES (SYNC_STAGES)
) u_checker (
  .CLK       (CLK),
  .rst       (rst),
  .snes_rd_n (snes_rd_n),
  .rd_valid  (rd_valid),
  .port_sel  (port_sel)
);

`default_nettype wire

// File: tb/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////
// expected response of one read
////////////////////////////////////////////////////////////

typedef struct packed {
  logic [23:0] rom_addr;
  // is_rom, is_saveram, is_writable
  logic [2:0]  flags;
  logic [2:0]  sel;
  // dspx_enable, dspx_a0
  logic [1:0]  dsp;
  logic [7:0]  data;
} expect_t;

// register contents of the three ports
logic [7:0] shadow [NUM_PORTS][8];

function automatic logic mapper_known(input logic [2:0] map);
  return (map == MAP_HIROM) || (map == MAP_LOROM) || (map == MAP_EXHIROM) || (map == MAP_MENU);
endfunction

// save RAM window by bank range and offset range
function automatic logic sram_window(input logic [2:0] map, input logic [23:0] a);
  logic [7:0]  bank;
  logic [15:0] off;
  bank = a[23:16] & 8'h7F;
  off  = a[15:0];
  case (map)
    MAP_HIROM, MAP_EXHIROM, MAP_MENU:
      return (bank >= 8'h20) && (bank <= 8'h3F) && (off >= 16'h6000) && (off <= 16'h7FFF);
    MAP_LOROM:
      return (bank >= 8'h70) && (bank <= 8'h7D) && (off < 16'h8000);
    default:
      return 1'b0;
  endcase
endfunction

function automatic logic [2:0] region_flags(input logic [2:0] map, input logic [23:0] a,
                                            input logic [23:0] sm);
  logic [7:0]  bank;
  logic [15:0] off;
  logic        sram;
  logic        rom;
  bank = a[23:16] & 8'h7F;
  off  = a[15:0];
  sram = sm[0] && sram_window(map, a);
  // banks 40-7f/c0-ff, or the upper half of any other bank
  rom  = mapper_known(map) && ((bank >= 8'h40) || (off >= 16'h8000));
  return {rom, sram, sram};
endfunction

function automatic logic [23:0] mapped_addr(input logic [2:0] map, input logic [23:0] a,
                                            input logic [23:0] sm, input logic [23:0] rm);
  logic [15:0] off;
  logic [15:0] win_off;
  logic [23:0] sram_off;
  off     = a[15:0];
  win_off = off - 16'h6000;
  if (!mapper_known(map)) begin
    return 24'h000000;
  end
  if (sm[0] && sram_window(map, a)) begin
    if (map == MAP_MENU) begin
      return MENU_SRAM_BASE + ({8'd0, win_off} & sm);
    end
    if (map == MAP_LOROM) begin
      // 32k per bank
      sram_off = ({19'd0, a[20:16]} << 15) | {9'd0, a[14:0]};
    end else begin
      // 8k per bank
      sram_off = ({19'd0, a[20:16]} << 13) + {8'd0, win_off};
    end
    return SAVERAM_BASE + (sram_off & sm);
  end
  case (map)
    MAP_LOROM:
      return (({17'd0, a[22:16]} << 15) | {9'd0, a[14:0]}) & rm;
    MAP_EXHIROM:
      return ((a[23] ? 24'h000000 : 24'h400000) | (a & 24'h3FFFFF)) & rm;
    MAP_MENU:
      return ((a & 24'h7FFFFF) & rm) + MENU_ROM_BASE;
    default:
      return (a & 24'h7FFFFF) & rm;
  endcase
endfunction

function automatic logic pa_213f_hit(input logic [7:0] fb, input logic [7:0] pa);
  return fb[FEAT_213F] && (pa == 8'h3F);
endfunction

// one-hot port select, 213F takes the MSU port first
function automatic logic [2:0] window_select(input logic [7:0] fb, input logic [23:0] a,
                                             input logic [7:0] pa);
  logic [2:0]  sel;
  logic [15:0] off;
  off = a[15:0];
  sel = 3'b000;
  if (pa_213f_hit(fb, pa)) begin
    sel[PORT_MSU] = 1'b1;
  end else if (fb[FEAT_MSU1] && !a[22] && (off >= 16'h2000) && (off <= 16'h2007)) begin
    sel[PORT_MSU] = 1'b1;
  end else if (fb[FEAT_SRTC] && !a[22] && (off >= 16'h2800) && (off <= 16'h2801)) begin
    sel[PORT_SRTC] = 1'b1;
  end else if ((a >= 24'hCCCCC0) && (a <= 24'hCCCCCF)) begin
    sel[PORT_CMD] = 1'b1;
  end
  return sel;
endfunction

function automatic logic [1:0] dsp_decode(input logic [2:0] map, input logic [7:0] fb,
                                          input logic [23:0] a, input logic [23:0] rm);
  logic [7:0]  bank;
  logic [15:0] off;
  bank = a[23:16] & 8'h7F;
  off  = a[15:0];
  if (!fb[FEAT_DSPX]) begin
    return 2'b01;
  end
  if (map == MAP_LOROM) begin
    // large ROMs move the DSP to 60-6f
    if (rm[20]) begin
      return {((bank >= 8'h60) && (bank <= 8'h6F) && (off < 16'h8000)), a[14]};
    end
    return {((bank >= 8'h30) && (bank <= 8'h3F) && (off >= 16'h8000)), a[14]};
  end
  if (map == MAP_HIROM) begin
    return {((bank <= 8'h0F) && (off >= 16'h6000) && (off <= 16'h7FFF)), a[12]};
  end
  return 2'b01;
endfunction

function automatic logic [2:0] port_reg_index(input logic [7:0] fb, input logic [23:0] a,
                                              input logic [7:0] pa);
  return pa_213f_hit(fb, pa) ? pa[2:0] : a[2:0];
endfunction

function automatic void write_shadow(input logic [7:0] fb, input logic [23:0] a,
                                     input logic [7:0] pa, input logic [7:0] d);
  logic [2:0] sel;
  logic [2:0] idx;
  sel = window_select(fb, a, pa);
  idx = port_reg_index(fb, a, pa);
  for (int p = 0; p < NUM_PORTS; p++) begin
    if (sel[p]) begin
      shadow[p][idx] = d;
    end
  end
endfunction

// open bus reads ff
function automatic logic [7:0] read_shadow(input logic [7:0] fb, input logic [23:0] a,
                                           input logic [7:0] pa);
  logic [2:0] sel;
  logic [2:0] idx;
  logic [7:0] d;
  sel = window_select(fb, a, pa);
  idx = port_reg_index(fb, a, pa);
  d   = 8'hFF;
  for (int p = 0; p < NUM_PORTS; p++) begin
    if (sel[p]) begin
      d = shadow[p][idx];
    end
  end
  return d;
endfunction

function automatic void clear_shadow();
  for (int p = 0; p < NUM_PORTS; p++) begin
    for (int i = 0; i < 8; i++) begin
      shadow[p][i] = 8'h00;
    end
  end
endfunction

`endif

// File: tb/tb_cart.sv
`default_nettype none

module tb_cart import map_pkg::*, bus_pkg::*; ();

  localparam int SYNC_STAGES   = 2;
  // cycles allowed from strobe to rd_valid
  localparam int VALID_TIMEOUT = 40;

  logic                 CLK;
  logic                 rst;
  logic [23:0]          snes_addr;
  logic [7:0]           snes_pa;
  logic                 snes_rd_n;
  logic                 snes_wr_n;
  logic [7:0]           snes_data_in;
  logic [2:0]           mapper;
  logic [7:0]           featurebits;
  logic [23:0]          saveram_mask;
  logic [23:0]          rom_mask;
  logic [23:0]          rom_addr;
  logic                 is_rom;
  logic                 is_saveram;
  logic                 is_writable;
  logic [NUM_PORTS-1:0] port_sel;
  logic                 dspx_enable;
  logic                 dspx_a0;
  logic [7:0]           rd_data;
  logic                 rd_valid;

  int          read_count;
  int          valid_count;
  logic [31:0] rnd;

  `include "tb_model.svh"

  expect_t exp_q [$];
  expect_t cur;

  logic [2:0]  map_list  [5] = '{MAP_HIROM, MAP_LOROM, MAP_EXHIROM, MAP_MENU, 3'd4};
  // msu, srtc, cmd, dsp lorom small/large, dsp hirom, msu in a rom bank
  logic [23:0] feat_addr [8] = '{24'h002003, 24'h802801, 24'hCCCCC5, 24'h3A8123,
                                 24'h604123, 24'h006000, 24'h0F7FFF, 24'h402000};

  cart_top #(
    .SYNC_STAGES (SYNC_STAGES)
  ) uut (
    .CLK          (CLK),
    .rst          (rst),
    .snes_addr    (snes_addr),
    .snes_pa      (snes_pa),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_data_in (snes_data_in),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .saveram_mask (saveram_mask),
    .rom_mask     (rom_mask),
    .rom_addr     (rom_addr),
    .is_rom       (is_rom),
    .is_saveram   (is_saveram),
    .is_writable  (is_writable),
    .port_sel     (port_sel),
    .dspx_enable  (dspx_enable),
    .dspx_a0      (dspx_a0),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid)
  );

  always #50 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] want);
    assert (got === want) else begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      fail_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // comparison process
  ////////////////////////////////////////////////////////////

  // outputs settle at the rising edge, sample in the middle of the cycle
  always @(negedge CLK) begin
    if (!rst && rd_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("rd_valid pulsed while no read was outstanding");
        fail_run();
      end
      cur = exp_q.pop_front();
      check_value("rom_addr", rom_addr, cur.rom_addr);
      check_value("is_rom", {23'd0, is_rom}, {23'd0, cur.flags[2]});
      check_value("is_saveram", {23'd0, is_saveram}, {23'd0, cur.flags[1]});
      check_value("is_writable", {23'd0, is_writable}, {23'd0, cur.flags[0]});
      check_value("port_sel", {21'd0, port_sel}, {21'd0, cur.sel});
      check_value("dspx_enable", {23'd0, dspx_enable}, {23'd0, cur.dsp[1]});
      check_value("dspx_a0", {23'd0, dspx_a0}, {23'd0, cur.dsp[0]});
      check_value("rd_data", {16'd0, rd_data}, {16'd0, cur.data});
      valid_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus cycles
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge CLK);
    #10;
  endtask

  // release has to pass the synchronizer before the FSM idles
  task automatic release_bus();
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    repeat (SYNC_STAGES + 2) next_cycle();
    assert (valid_count == read_count) else begin
      $display("got %0d rd_valid pulses for %0d reads", valid_count, read_count);
      fail_run();
    end
  endtask

  task automatic bus_read(input logic [23:0] a, input logic [7:0] pa, input int hold);
    expect_t e;
    int      waited;
    e.rom_addr = mapped_addr(mapper, a, saveram_mask, rom_mask);
    e.flags    = region_flags(mapper, a, saveram_mask);
    e.sel      = window_select(featurebits, a, pa);
    e.dsp      = dsp_decode(mapper, featurebits, a, rom_mask);
    e.data     = read_shadow(featurebits, a, pa);
    exp_q.push_back(e);
    snes_addr = a;
    snes_pa   = pa;
    snes_rd_n = 1'b0;
    read_count++;
    waited = 0;
    while (valid_count != read_count) begin
      next_cycle();
      waited++;
      assert (waited <= VALID_TIMEOUT) else begin
        $display("timed out waiting for rd_valid after a read of %h", a);
        fail_run();
      end
    end
    repeat (hold) next_cycle();
    release_bus();
  endtask

  // write lands at wr_hit, SYNC_STAGES+2 edges after the strobe
  task automatic bus_write(input logic [23:0] a, input logic [7:0] pa, input logic [7:0] d);
    write_shadow(featurebits, a, pa, d);
    snes_addr    = a;
    snes_pa      = pa;
    snes_data_in = d;
    snes_wr_n    = 1'b0;
    repeat (SYNC_STAGES + 3) next_cycle();
    release_bus();
  endtask

  // half the addresses aimed at the save RAM windows
  function automatic logic [23:0] random_addr();
    logic [31:0] r;
    logic [31:0] s;
    r = $urandom();
    s = $urandom();
    case (s[1:0])
      2'd0:    return {r[23], 2'b01, r[20:16], 3'b011, r[12:0]};
      2'd1:    return {r[23], 3'b111, r[19:16], 1'b0, r[14:0]};
      default: return r[23:0];
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h6d3f));
    CLK          = 1'b0;
    rst          = 1'b1;
    snes_addr    = 24'h000000;
    snes_pa      = 8'h00;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    snes_data_in = 8'h00;
    mapper       = MAP_HIROM;
    featurebits  = 8'h00;
    saveram_mask = 24'h001FFF;
    rom_mask     = 24'h3FFFFF;
    read_count   = 0;
    valid_count  = 0;
    clear_shadow();
    repeat (8) next_cycle();
    rst = 1'b0;
    next_cycle();

    // random translation under every mapper plus one unmapped code
    for (int m = 0; m < 5; m++) begin
      mapper = map_list[m];
      for (int i = 0; i < 40; i++) begin
        rnd          = $urandom();
        featurebits  = rnd[7:0];
        saveram_mask = {rnd[31:24], rnd[15:0]};
        rnd          = $urandom();
        rom_mask     = rnd[23:0];
        bus_read(random_addr(), rnd[31:24], int'(rnd[25:24]));
      end
    end

    // feature selects with all feature bits on, then all off
    saveram_mask = 24'h001FFF;
    for (int m = 0; m < 2; m++) begin
      mapper = map_list[m];
      for (int k = 0; k < 4; k++) begin
        rom_mask    = k[0] ? 24'h1FFFFF : 24'h0FFFFF;
        featurebits = k[1] ? 8'h00 : 8'h1D;
        for (int i = 0; i < 8; i++) begin
          bus_read(feat_addr[i], 8'h00, 0);
          bus_read(feat_addr[i], 8'h3F, 0);
        end
      end
    end

    // fill every port window, then read it all back
    mapper      = MAP_HIROM;
    featurebits = 8'h1D;
    rom_mask    = 24'h3FFFFF;
    for (int i = 0; i < 8; i++) begin
      rnd = $urandom();
      bus_write({16'h0020, 5'd0, i[2:0]}, 8'h00, rnd[7:0]);
      bus_write({20'hCCCCC, 1'b0, i[2:0]}, 8'h00, rnd[15:8]);
    end
    for (int i = 0; i < 2; i++) begin
      rnd = $urandom();
      bus_write({16'h0028, 5'd0, i[2:0]}, 8'h00, rnd[7:0]);
    end
    // 213F write lands in MSU register 7
    bus_write(24'h018000, 8'h3F, 8'hA5);
    for (int i = 0; i < 16; i++) begin
      bus_read({16'h0020, 4'd0, i[3:0]}, 8'h00, 0);
      bus_read({16'h0028, 4'd0, i[3:0]}, 8'h00, 0);
      bus_read({20'hCCCCC, i[3:0]}, 8'h00, 0);
    end
    bus_read(24'h018000, 8'h3F, 0);
    // outside every window
    bus_read(24'h408000, 8'h00, 0);
    bus_read(24'h002008, 8'h00, 0);
    bus_read(24'hCCCCD0, 8'h00, 0);

    // a long strobe still counts as one read
    bus_read(24'h002001, 8'h00, 20);

    // reset in the middle of the run
    rst = 1'b1;
    repeat (8) next_cycle();
    rst = 1'b0;
    clear_shadow();
    repeat (10) next_cycle();
    assert (valid_count == read_count) else begin
      $display("rd_valid pulsed after reset without a strobe");
      fail_run();
    end
    for (int i = 0; i < 8; i++) begin
      bus_read({16'h0020, 5'd0, i[2:0]}, 8'h00, 0);
      bus_read({20'hCCCCC, 1'b0, i[2:0]}, 8'h00, 0);
    end
    bus_read(24'h002800, 8'h00, 0);
    bus_read(24'h002801, 8'h00, 0);
    bus_read(24'h018000, 8'h3F, 0);

    if (valid_count == read_count && exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("run ended with %0d reads and %0d rd_valid pulses", read_count, valid_count);
      fail_run();
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+tb
verilog/map_pkg.sv
verilog/bus_pkg.sv
verilog/snes_bus_sampler.sv
verilog/address.sv
verilog/io_port.sv
verilog/port_read_mux.sv
verilog/cart_top.sv
tb/cart_checker.sv
tb/tb_cart.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cart testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_cart \
  -f list.f \
  -o Vtb_cart

# the simulator may stop early, the pass line decides
output="$(./obj_dir/Vtb_cart 2>&1 || true)"
printf '%s\n' "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
